/* filelist.f */
hw/dma_timing_pkg.sv
hw/dma_mode_decode.sv
hw/dma_cycle_fsm.sv
hw/dma_bus_strobes.sv
hw/dma_tc_status.sv
hw/dma_timing_top.sv
tests/dma_timing_tb.sv

/* hw/dma_bus_strobes.sv */
/*
 * DMA bus strobe generator
 * Registered hold, address, acknowledge and read/write strobes per cycle state
 */
`timescale 1ns/1ps

module dma_bus_strobes (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           master_clear_i,
    input  dma_timing_pkg::cycle_state_e   state_i,
    input  dma_timing_pkg::chan_mask_t     ack_mask_i,
    input  dma_timing_pkg::transfer_type_e type_i,
    input  logic                           compressed_i,
    input  logic                           extended_write_i,
    input  logic                           dack_high_i,
    output logic                           hold_request_o,
    output logic                           aen_o,
    output logic                           adstb_o,
    output dma_timing_pkg::chan_mask_t     dack_o,
    output logic                           mem_read_o,
    output logic                           mem_write_o,
    output logic                           io_read_o,
    output logic                           io_write_o
);
    import dma_timing_pkg::*;

    logic       bus_owned;
    logic       dack_active;
    logic       read_phase;
    logic       write_phase;
    chan_mask_t dack_level;

    // ==============================
    // State decode
    // ==============================
    assign bus_owned   = (state_i == S1) || (state_i == S2) || (state_i == S3)
                      || (state_i == SW) || (state_i == S4);
    assign dack_active = bus_owned && (state_i != S1);
    assign read_phase  = (state_i == S2) || (state_i == S3) || (state_i == SW);
    // Write side starts a state early under extended write or compressed timing
    assign write_phase = (state_i == S3) || (state_i == SW)
                      || ((state_i == S2) && (extended_write_i || compressed_i));

    assign dack_level  = dack_active ? ack_mask_i : '0;

    // ==============================
    // Output registers
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset || master_clear_i) begin
            hold_request_o <= 1'b0;
            aen_o          <= 1'b0;
            adstb_o        <= 1'b0;
            dack_o         <= '1;
            mem_read_o     <= 1'b0;
            mem_write_o    <= 1'b0;
            io_read_o      <= 1'b0;
            io_write_o     <= 1'b0;
        end else begin
            hold_request_o <= (state_i != SI);
            aen_o          <= bus_owned;
            adstb_o        <= (state_i == S1);
            dack_o         <= dack_high_i ? dack_level : ~dack_level;
            // Write type moves I/O to memory, read type memory to I/O
            mem_read_o     <= read_phase && (type_i == READ);
            io_read_o      <= read_phase && (type_i == WRITE);
            mem_write_o    <= write_phase && (type_i == WRITE);
            io_write_o     <= write_phase && (type_i == READ);
        end
    end

endmodule

/* hw/dma_cycle_fsm.sv */
/*
 * DMA cycle state machine
 * Steps SI through S4 for the granted channel and flags each finished word
 */
`timescale 1ns/1ps

module dma_cycle_fsm (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           master_clear_i,
    input  dma_timing_pkg::chan_mask_t     grant_i,
    input  dma_timing_pkg::chan_mask_t     dreq_i,
    input  logic                           hold_ack_i,
    input  logic                           ready_i,
    input  logic                           compressed_i,
    input  dma_timing_pkg::transfer_type_e type_i,
    input  dma_timing_pkg::transfer_mode_e mode_i,
    input  logic                           eop_i,
    output dma_timing_pkg::cycle_state_e   state_o,
    output dma_timing_pkg::channel_t       channel_o,
    output dma_timing_pkg::chan_mask_t     ack_mask_o,
    output logic                           next_word_o
);
    import dma_timing_pkg::*;

    cycle_state_e next_state;
    logic         verify_type;
    logic         request_gone;

    // Illegal type moves no data either
    assign verify_type  = (type_i == VERIFY) || (type_i == ILLEGAL);
    assign request_gone = ((ack_mask_o & dreq_i) == '0);

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        next_state = state_o;
        case (state_o)
            SI: begin
                if (grant_i != '0)
                    next_state = S0;
            end
            S0: begin
                // Wait for the bus
                if (hold_ack_i)
                    next_state = S1;
            end
            S1: next_state = S2;
            S2: begin
                if (!compressed_i)
                    next_state = S3;
                else if (verify_type && ready_i)
                    next_state = S4;
                else
                    next_state = SW;
            end
            S3: next_state = SW;
            SW: begin
                if (ready_i)
                    next_state = S4;
            end
            S4: begin
                case (mode_i)
                    BLOCK:   next_state = eop_i ? SI : S2;
                    DEMAND:  next_state = (eop_i || request_gone) ? SI : S2;
                    default: next_state = SI;
                endcase
            end
            default: next_state = SI;
        endcase
    end

    assign next_word_o = (next_state == S4);

    // ==============================
    // State and channel latch
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_o <= SI;
        end else if (master_clear_i) begin
            state_o <= SI;
        end else begin
            state_o <= next_state;
        end
    end

    // Grant is sampled only while idle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack_mask_o <= '0;
        end else if (master_clear_i) begin
            ack_mask_o <= '0;
        end else if (state_o == SI) begin
            ack_mask_o <= grant_i;
        end
    end

    // Channel number from the one-hot mask
    always_comb begin
        channel_o = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (ack_mask_o[i])
                channel_o = channel_t'(i);
        end
    end

endmodule

/* hw/dma_mode_decode.sv */
/*
 * DMA mode decode
 * Command and per-channel mode registers, settings of the active channel
 */
`timescale 1ns/1ps

module dma_mode_decode (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [7:0]                     data_i,
    input  logic                           write_command_i,
    input  logic                           write_mode_i,
    input  logic                           master_clear_i,
    input  dma_timing_pkg::channel_t       channel_i,
    output logic                           compressed_o,
    output logic                           extended_write_o,
    output logic                           dack_high_o,
    output dma_timing_pkg::transfer_type_e type_o,
    output dma_timing_pkg::transfer_mode_e mode_o
);
    import dma_timing_pkg::*;

    // Command byte bits
    localparam int CMD_COMPRESSED_BIT = 3;
    localparam int CMD_EXT_WRITE_BIT  = 5;
    localparam int CMD_DACK_HIGH_BIT  = 7;

    // Mode byte fields, two bits each
    localparam int MODE_CHANNEL_LSB = 0;
    localparam int MODE_TYPE_LSB    = 2;
    localparam int MODE_MODE_LSB    = 6;

    transfer_type_e chan_type [NUM_CHANNELS];
    transfer_mode_e chan_mode [NUM_CHANNELS];
    channel_t       mode_channel;

    assign mode_channel = channel_t'(data_i[MODE_CHANNEL_LSB +: 2]);

    // ==============================
    // Command register
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset || master_clear_i) begin
            compressed_o     <= 1'b0;
            extended_write_o <= 1'b0;
            dack_high_o      <= 1'b0;
        end else if (write_command_i) begin
            compressed_o     <= data_i[CMD_COMPRESSED_BIT];
            extended_write_o <= data_i[CMD_EXT_WRITE_BIT];
            dack_high_o      <= data_i[CMD_DACK_HIGH_BIT];
        end
    end

    // ==============================
    // Mode registers
    // ==============================
    // Only the channel named in the byte is written
    always_ff @(posedge clock or posedge reset) begin
        if (reset || master_clear_i) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                chan_type[i] <= VERIFY;
                chan_mode[i] <= DEMAND;
            end
        end else if (write_mode_i) begin
            chan_type[mode_channel] <= transfer_type_e'(data_i[MODE_TYPE_LSB +: 2]);
            chan_mode[mode_channel] <= transfer_mode_e'(data_i[MODE_MODE_LSB +: 2]);
        end
    end

    // Settings of the channel in service
    assign type_o = chan_type[channel_i];
    assign mode_o = chan_mode[channel_i];

endmodule

/* hw/dma_tc_status.sv */
/*
 * DMA end-of-process and terminal-count status
 * Samples underflow or the EOP pin per word and collects finished channels
 */
`timescale 1ns/1ps

module dma_tc_status (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       master_clear_i,
    input  logic                       next_word_i,
    input  logic                       underflow_i,
    input  logic                       eop_in_i,
    input  dma_timing_pkg::chan_mask_t ack_mask_i,
    input  logic                       read_status_i,
    output logic                       eop_o,
    output dma_timing_pkg::chan_mask_t status_o
);
    logic read_status_q;

    // High for the S4 cycle of a word that ends the transfer
    always_ff @(posedge clock or posedge reset) begin
        if (reset || master_clear_i) begin
            eop_o <= 1'b0;
        end else begin
            eop_o <= next_word_i && (underflow_i || eop_in_i);
        end
    end

    // ==============================
    // Status register
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            read_status_q <= 1'b0;
            status_o      <= '0;
        end else begin
            read_status_q <= read_status_i;
            if (master_clear_i || (read_status_q && !read_status_i))
                status_o <= '0;
            else if (eop_o)
                status_o <= status_o | ack_mask_i;
        end
    end

endmodule

/* hw/dma_timing_pkg.sv */
/*
 * DMA timing and control shared types
 * Channel, transfer and cycle state definitions used across the controller
 */
package dma_timing_pkg;

    // ==============================
    // Channel sizing
    // ==============================
    localparam int NUM_CHANNELS = 4;

    typedef logic [1:0]              channel_t;
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

    // ==============================
    // Mode register encodings
    // ==============================
    // Illegal type gives no strobes, same as verify
    typedef enum logic [1:0] {
        VERIFY  = 2'd0,
        WRITE   = 2'd1,
        READ    = 2'd2,
        ILLEGAL = 2'd3
    } transfer_type_e;

    // Cascade runs as single
    typedef enum logic [1:0] {
        DEMAND  = 2'd0,
        SINGLE  = 2'd1,
        BLOCK   = 2'd2,
        CASCADE = 2'd3
    } transfer_mode_e;

    // ==============================
    // Cycle states
    // ==============================
    typedef enum logic [2:0] {
        SI, S0, S1, S2, S3, SW, S4
    } cycle_state_e;

endpackage

/* hw/dma_timing_top.sv */
/*
 * DMA timing and control top level
 * Mode decode, cycle state machine, bus strobes and status
 */
`timescale 1ns/1ps

module dma_timing_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [7:0]                 data_i,
    input  logic                       write_command_i,
    input  logic                       write_mode_i,
    input  logic                       master_clear_i,
    input  logic                       read_status_i,
    input  dma_timing_pkg::chan_mask_t grant_i,
    input  dma_timing_pkg::chan_mask_t dreq_i,
    input  logic                       hold_ack_i,
    input  logic                       ready_i,
    input  logic                       underflow_i,
    input  logic                       eop_in_i,
    output logic                       hold_request_o,
    output logic                       aen_o,
    output logic                       adstb_o,
    output dma_timing_pkg::chan_mask_t dack_o,
    output logic                       mem_read_o,
    output logic                       mem_write_o,
    output logic                       io_read_o,
    output logic                       io_write_o,
    output logic                       end_of_process_o,
    output dma_timing_pkg::chan_mask_t status_o
);
    import dma_timing_pkg::*;

    channel_t       channel;
    chan_mask_t     ack_mask;
    cycle_state_e   state;
    transfer_type_e xfer_type;
    transfer_mode_e xfer_mode;
    logic           compressed;
    logic           extended_write;
    logic           dack_high;
    logic           next_word;
    logic           eop;

    // Decode
    dma_mode_decode u_decode (
        .clock(clock), .reset(reset), .data_i(data_i),
        .write_command_i(write_command_i), .write_mode_i(write_mode_i),
        .master_clear_i(master_clear_i), .channel_i(channel),
        .compressed_o(compressed), .extended_write_o(extended_write),
        .dack_high_o(dack_high), .type_o(xfer_type), .mode_o(xfer_mode)
    );

    // Execute
    dma_cycle_fsm u_fsm (
        .clock(clock), .reset(reset), .master_clear_i(master_clear_i),
        .grant_i(grant_i), .dreq_i(dreq_i), .hold_ack_i(hold_ack_i),
        .ready_i(ready_i), .compressed_i(compressed), .type_i(xfer_type),
        .mode_i(xfer_mode), .eop_i(eop), .state_o(state),
        .channel_o(channel), .ack_mask_o(ack_mask), .next_word_o(next_word)
    );

    // Result
    dma_bus_strobes u_strobes (
        .clock(clock), .reset(reset), .master_clear_i(master_clear_i),
        .state_i(state), .ack_mask_i(ack_mask), .type_i(xfer_type),
        .compressed_i(compressed), .extended_write_i(extended_write),
        .dack_high_i(dack_high), .hold_request_o(hold_request_o),
        .aen_o(aen_o), .adstb_o(adstb_o), .dack_o(dack_o),
        .mem_read_o(mem_read_o), .mem_write_o(mem_write_o),
        .io_read_o(io_read_o), .io_write_o(io_write_o)
    );

    dma_tc_status u_status (
        .clock(clock), .reset(reset), .master_clear_i(master_clear_i),
        .next_word_i(next_word), .underflow_i(underflow_i),
        .eop_in_i(eop_in_i), .ack_mask_i(ack_mask),
        .read_status_i(read_status_i), .eop_o(eop), .status_o(status_o)
    );

    assign end_of_process_o = eop;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the DMA timing testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dma_timing_tb -f filelist.f -o dma_timing_sim \
    || { echo "Verilator build failed"; exit 1; }

output="$(./obj_dir/dma_timing_sim)"
echo "$output"
echo "$output" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tests/dma_timing_tb.sv */
/*
 * Testbench for the DMA timing and control top level
 * Single, block, demand and verify transfers checked against a reference model
 */
`timescale 1ns/1ps

module dma_timing_tb;
    import dma_timing_pkg::*;

    // Pulse counter slots
    localparam int MEM_READ  = 6;
    localparam int MEM_WRITE = 5;
    localparam int IO_READ   = 4;
    localparam int IO_WRITE  = 3;
    localparam int ADSTB     = 2;
    localparam int AEN       = 1;
    localparam int EOP       = 0;

    // How a transfer is ended
    localparam int END_NONE      = 0;
    localparam int END_UNDERFLOW = 1;
    localparam int END_EOP_PIN   = 2;
    localparam int END_DREQ      = 3;

    logic       clock = 1'b0;
    logic       reset;
    logic [7:0] data_i;
    logic       write_command_i, write_mode_i, master_clear_i, read_status_i;
    chan_mask_t grant_i, dreq_i, dack_o, status_o;
    logic       hold_ack_i, ready_i, underflow_i, eop_in_i;
    logic       hold_request_o, aen_o, adstb_o, end_of_process_o;
    logic       mem_read_o, mem_write_o, io_read_o, io_write_o;

    int          pulse_cnt [7];
    logic [6:0]  now_bits;
    logic [6:0]  prev_bits = '0;
    logic        was_counting = 1'b0;
    logic        counting;
    logic        idle_check;
    logic        dack_high_cmd;
    chan_mask_t  dack_seen;
    logic [3:0]  exp_strobes;
    int          exp_words;
    int          exp_cnt;
    chan_mask_t  exp_status;
    chan_mask_t  exp_mask;
    logic        exp_eop;
    logic [15:0] lfsr_state;
    int          error_count;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          guard;
    int          chan;
    int          length;

    dma_timing_top uut (.*);

    always #4 clock = ~clock;

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Expected outcome of one transfer from its mode byte and end condition
    function automatic void expected_transfer(
        input  logic [1:0] ttype,
        input  logic [1:0] tmode,
        input  int         end_word,
        input  logic       ends_by_eop,
        input  chan_mask_t mask,
        output logic [3:0] strobes,
        output int         words,
        output chan_mask_t status
    );
        // Order is mem_read, mem_write, io_read, io_write
        case (ttype)
            WRITE:   strobes = 4'b0110;
            READ:    strobes = 4'b1001;
            default: strobes = 4'b0000;
        endcase
        words  = (tmode == SINGLE || tmode == CASCADE) ? 1 : end_word;
        status = ends_by_eop ? mask : '0;
    endfunction

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        error_count++;
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout at %0t: %s", $time, reason);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // ==============================
    // Checker
    // ==============================
    // Sampled on the falling edge, half a cycle after outputs settle
    always @(negedge clock) begin
        now_bits = {mem_read_o, mem_write_o, io_read_o, io_write_o,
                    adstb_o, aen_o, end_of_process_o};
        if (idle_check) begin
            if (now_bits != 7'd0 || hold_request_o)
                report_mismatch("idle outputs", int'({hold_request_o, now_bits}), 0);
            if (dack_o != 4'b1111)
                report_mismatch("idle dack", int'(dack_o), 15);
            if (status_o != 4'b0000)
                report_mismatch("idle status", int'(status_o), 0);
        end
        if (counting) begin
            for (int i = 0; i < 7; i++) begin
                if (now_bits[i] && !prev_bits[i])
                    pulse_cnt[i] = pulse_cnt[i] + 1;
            end
            dack_seen = dack_seen | (dack_high_cmd ? dack_o : ~dack_o);
        end else if (was_counting) begin
            exp_cnt = exp_strobes[3] ? exp_words : 0;
            if (pulse_cnt[MEM_READ] != exp_cnt)
                report_mismatch("mem_read pulses", pulse_cnt[MEM_READ], exp_cnt);
            exp_cnt = exp_strobes[2] ? exp_words : 0;
            if (pulse_cnt[MEM_WRITE] != exp_cnt)
                report_mismatch("mem_write pulses", pulse_cnt[MEM_WRITE], exp_cnt);
            exp_cnt = exp_strobes[1] ? exp_words : 0;
            if (pulse_cnt[IO_READ] != exp_cnt)
                report_mismatch("io_read pulses", pulse_cnt[IO_READ], exp_cnt);
            exp_cnt = exp_strobes[0] ? exp_words : 0;
            if (pulse_cnt[IO_WRITE] != exp_cnt)
                report_mismatch("io_write pulses", pulse_cnt[IO_WRITE], exp_cnt);
            if (pulse_cnt[ADSTB] != 1)
                report_mismatch("adstb pulses", pulse_cnt[ADSTB], 1);
            if (pulse_cnt[AEN] != 1)
                report_mismatch("aen pulses", pulse_cnt[AEN], 1);
            if (pulse_cnt[EOP] != int'(exp_eop))
                report_mismatch("end of process pulses", pulse_cnt[EOP], int'(exp_eop));
            if (dack_seen != exp_mask)
                report_mismatch("acknowledged channels", int'(dack_seen), int'(exp_mask));
            if (status_o != exp_status)
                report_mismatch("status bits", int'(status_o), int'(exp_status));
        end
        if (!counting) begin
            for (int i = 0; i < 7; i++)
                pulse_cnt[i] = 0;
            dack_seen = '0;
        end
        was_counting = counting;
        prev_bits    = now_bits;
    end

    // ==============================
    // Stimulus tasks
    // ==============================
    task automatic check_idle();
        idle_check = 1'b1;
        @(posedge clock);
        #1;
        idle_check = 1'b0;
    endtask

    task automatic write_command(input logic [7:0] value);
        data_i          = value;
        write_command_i = 1'b1;
        dack_high_cmd   = value[7];
        @(posedge clock);
        #1;
        write_command_i = 1'b0;
    endtask

    task automatic write_mode(input logic [1:0] ttype, input logic [1:0] tmode,
                              input int chan_num);
        data_i       = {tmode, 2'b00, ttype, chan_num[1:0]};
        write_mode_i = 1'b1;
        @(posedge clock);
        #1;
        write_mode_i = 1'b0;
    endtask

    task automatic wait_for_hold();
        int cycles;
        cycles = 0;
        while (!hold_request_o) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > 10)
                abort_run("hold request never rose");
        end
    endtask

    // Status must clear once the read pulse has ended
    task automatic clear_status();
        int cycles;
        read_status_i = 1'b1;
        @(posedge clock);
        #1;
        read_status_i = 1'b0;
        cycles = 0;
        while (status_o != 4'b0000) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > 5)
                abort_run("status bits did not clear after the status read");
        end
    endtask

    task automatic run_transfer(input logic [1:0] ttype, input logic [1:0] tmode,
                                input int chan_num, input int end_word, input int end_kind);
        chan_mask_t mask;
        int         waits;
        int         cyc;
        int         words_done;
        mask = 4'b0001 << chan_num;
        take_bits(2, waits);
        exp_eop  = (end_kind == END_UNDERFLOW) || (end_kind == END_EOP_PIN);
        exp_mask = mask;
        expected_transfer(ttype, tmode, end_word, exp_eop, mask,
                          exp_strobes, exp_words, exp_status);
        write_mode(ttype, tmode, chan_num);
        counting = 1'b1;
        grant_i  = mask;
        dreq_i   = mask;
        wait_for_hold();
        // Grant is held until the cycle has started
        grant_i    = '0;
        hold_ack_i = 1'b1;
        cyc = 0;
        while (hold_request_o) begin
            @(posedge clock);
            #1;
            cyc++;
            ready_i     = (cyc % (waits + 1)) == 0;
            words_done  = pulse_cnt[MEM_READ] + pulse_cnt[IO_READ];
            underflow_i = (end_kind == END_UNDERFLOW) && (words_done >= end_word);
            eop_in_i    = (end_kind == END_EOP_PIN) && (words_done >= end_word);
            if (end_kind == END_DREQ && words_done >= end_word)
                dreq_i = '0;
            if (cyc > 300)
                abort_run("transfer never released the hold request");
        end
        hold_ack_i  = 1'b0;
        dreq_i      = '0;
        underflow_i = 1'b0;
        eop_in_i    = 1'b0;
        ready_i     = 1'b1;
        counting    = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        lfsr_state      = 16'd3;
        reset           = 1'b1;
        data_i          = '0;
        write_command_i = 1'b0;
        write_mode_i    = 1'b0;
        master_clear_i  = 1'b0;
        read_status_i   = 1'b0;
        grant_i         = '0;
        dreq_i          = '0;
        hold_ack_i      = 1'b0;
        ready_i         = 1'b1;
        underflow_i     = 1'b0;
        eop_in_i        = 1'b0;
        counting        = 1'b0;
        idle_check      = 1'b0;
        dack_high_cmd   = 1'b0;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // Reset values, then a master clear part way through a read
        begin_test();
        check_idle();
        write_command(8'h80);
        write_mode(READ, SINGLE, 0);
        grant_i = 4'b0001;
        wait_for_hold();
        grant_i    = '0;
        hold_ack_i = 1'b1;
        guard      = 0;
        while (!aen_o) begin
            @(posedge clock);
            #1;
            guard++;
            if (guard > 10)
                abort_run("address enable never rose");
        end
        master_clear_i = 1'b1;
        @(posedge clock);
        #1;
        master_clear_i = 1'b0;
        hold_ack_i     = 1'b0;
        dack_high_cmd  = 1'b0;
        check_idle();
        end_test("reset and master clear");

        begin_test();
        take_bits(2, chan);
        write_command(8'h00);
        run_transfer(WRITE, SINGLE, chan, 1, END_NONE);
        end_test("single write");

        begin_test();
        take_bits(2, chan);
        take_bits(2, length);
        run_transfer(READ, BLOCK, chan, length + 1, END_UNDERFLOW);
        clear_status();
        end_test("block read with underflow");

        // Request dropped first, then ended by the EOP pin
        begin_test();
        take_bits(2, chan);
        take_bits(2, length);
        run_transfer(READ, DEMAND, chan, length + 1, END_DREQ);
        take_bits(2, length);
        run_transfer(READ, DEMAND, chan, length + 1, END_EOP_PIN);
        clear_status();
        end_test("demand read");

        begin_test();
        take_bits(2, chan);
        write_command(8'h80);
        run_transfer(WRITE, SINGLE, chan, 1, END_NONE);
        write_command(8'h08);
        run_transfer(WRITE, SINGLE, chan, 1, END_NONE);
        end_test("command options");

        begin_test();
        take_bits(2, chan);
        write_command(8'h00);
        run_transfer(VERIFY, SINGLE, chan, 1, END_NONE);
        end_test("verify transfer");

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
